// ==== vlog.f ====
hdl/mem_cfg_pkg.sv
hdl/mem_req_pkg.sv
hdl/req_stream_if.sv
hdl/request_queue.sv
hdl/priority_arbiter.sv
hdl/response_router.sv
hdl/mem_arbiter_top.sv
tests/tb_mem_arbiter.sv

// ==== Bender.yml ====
package:
  name: mem_arbiter

sources:
  - hdl/mem_cfg_pkg.sv
  - hdl/mem_req_pkg.sv
  - hdl/req_stream_if.sv
  - hdl/request_queue.sv
  - hdl/priority_arbiter.sv
  - hdl/response_router.sv
  - hdl/mem_arbiter_top.sv
  - target: test
    files:
      - tests/tb_mem_arbiter.sv

// ==== tests/tb_mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_arbiter;

    localparam int NUM_TESTS = 5;

    logic                                                   clk_in;
    logic                                                   reset_in;
    mem_req_pkg::mem_req_t [mem_cfg_pkg::NUM_SOURCES-1:0]   req_data;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]                    req_critical;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]                    req_valid;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]                    req_ack;
    mem_req_pkg::mem_req_t                                  mem_req;
    logic                                                   mem_req_valid;
    logic                                                   mem_req_ack;
    mem_req_pkg::mem_resp_t                                 mem_resp = '0;
    logic                                                   mem_resp_valid = 1'b0;
    mem_req_pkg::mem_resp_t                                 resp_data;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]                    resp_valid;

    int                     cycle = 0;
    int                     resp_delay = 3;     // memory latency in cycles
    logic                   hold_resp = 1'b0;   // withhold memory responses
    int                     last_hs_cycle;

    mem_req_pkg::mem_req_t  sent_reqs [$];      // handed to the DUT, not yet issued
    int                     issue_src [$];
    int                     issue_cycle [$];
    int                     exp_src [$];        // scoreboard, in issue order
    logic [31:0]            exp_data [$];
    logic [31:0]            pend_data [$];      // memory model
    int                     pend_due [$];

    logic                   stall_seen = 1'b0;
    mem_req_pkg::mem_req_t  held_req;
    logic                   prev_mresp = 1'b0;

    mem_arbiter_top DUT
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .req_data       (req_data),
        .req_critical   (req_critical),
        .req_valid      (req_valid),
        .req_ack        (req_ack),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ack    (mem_req_ack),
        .mem_resp       (mem_resp),
        .mem_resp_valid (mem_resp_valid),
        .resp_data      (resp_data),
        .resp_valid     (resp_valid)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [65:0] actual,
                               input logic [65:0] expected);
        assert (actual === expected)
        else stop_with_error($sformatf("MISMATCH %s: expected 0x%0h, got 0x%0h",
                                       name, expected, actual));
    endtask

    initial
    begin
        #(NUM_TESTS * 2000);
        stop_with_error("watchdog timeout, the tests did not complete in time");
    end

    // low address bits carry the source so issued requests can be traced back
    function automatic mem_req_pkg::mem_req_t make_req(input int src);
        mem_req_pkg::mem_req_t r;
        r.op    = ($urandom() & 1) ? mem_req_pkg::op_write : mem_req_pkg::op_read;
        r.addr  = ($urandom() & 32'hffff_fffc) | src;
        r.wdata = $urandom();
        return r;
    endfunction

    // memory model, one in-order response per cycle
    always @(posedge clk_in)
    begin
        cycle = cycle + 1;
        #1;
        mem_resp_valid = 1'b0;
        if (!hold_resp && pend_data.size() > 0 && pend_due[0] <= cycle)
        begin
            mem_resp.rdata = pend_data.pop_front();
            void'(pend_due.pop_front());
            mem_resp_valid = 1'b1;
        end
    end

    task automatic log_issue();
        int src;
        int idx;
        int k;
        src = int'(mem_req.addr[mem_cfg_pkg::SRC_W-1:0]);
        idx = -1;
        for (k = sent_reqs.size() - 1; k >= 0; k--)
            if (sent_reqs[k].addr[mem_cfg_pkg::SRC_W-1:0] == src)
                idx = k;  // oldest one of this source
        assert (idx >= 0) else stop_with_error("memory request issued that no requester sent");
        check_value("mem_req", mem_req, sent_reqs[idx]);
        sent_reqs.delete(idx);
        issue_src.push_back(src);
        issue_cycle.push_back(cycle);
        exp_src.push_back(src);
        exp_data.push_back(mem_req.addr + 1);
        pend_data.push_back(mem_req.addr + 1);
        pend_due.push_back(cycle + resp_delay);
    endtask

    // mid-cycle monitor and scoreboard
    always @(negedge clk_in)
    begin
        if (!reset_in)
        begin
            if (stall_seen)
                assert (mem_req_valid && mem_req === held_req)
                else stop_with_error("mem_req changed or dropped while mem_req_ack was low");
            if (mem_req_valid && mem_req_ack)
                log_issue();
            stall_seen = mem_req_valid && !mem_req_ack;
            held_req   = mem_req;

            assert ((resp_valid != 0) == prev_mresp)
            else stop_with_error("resp_valid did not follow mem_resp_valid by one cycle");
            if (resp_valid != 0)
            begin
                assert (exp_src.size() > 0)
                else stop_with_error("response returned with no request outstanding");
                check_value("resp_valid", resp_valid, 3'b001 << exp_src[0]);
                check_value("resp_data", resp_data.rdata, exp_data[0]);
                void'(exp_src.pop_front());
                void'(exp_data.pop_front());
            end
            prev_mresp = mem_resp_valid;
        end
    end

    task automatic set_mem_ack(input logic value);
        @(posedge clk_in);
        #1;
        mem_req_ack = value;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    // one request per source in mask, each held until its own ack
    task automatic send_requests(input logic [2:0] mask, input logic [2:0] crit);
        logic [2:0] pending;
        int s;
        pending = mask;
        @(posedge clk_in);
        #1;
        for (s = 0; s < mem_cfg_pkg::NUM_SOURCES; s++)
        begin
            if (mask[s])
            begin
                req_data[s] = make_req(s);
                sent_reqs.push_back(req_data[s]);
            end
        end
        req_critical = crit;
        req_valid    = mask;
        while (pending != 0)
        begin
            @(negedge clk_in);
            if ((pending & req_ack) != 0)
                last_hs_cycle = cycle;
            pending = pending & ~req_ack;
            @(posedge clk_in);
            #1;
            req_valid = pending;
        end
    endtask

    task automatic wait_until_drained();
        @(negedge clk_in);
        while (sent_reqs.size() > 0 || pend_data.size() > 0 || exp_src.size() > 0)
            @(negedge clk_in);
    endtask

    task automatic single_request();
        int base;
        base = issue_src.size();
        set_mem_ack(1'b1);
        send_requests(3'b010, 3'b000);
        wait_until_drained();
        check_value("cycles from handshake to mem_req_valid",
                    issue_cycle[base] - last_hs_cycle, 2);
    endtask

    task automatic round_robin_order();
        int base;
        base = issue_src.size();
        set_mem_ack(1'b0);
        send_requests(3'b111, 3'b000);  // last issued was source 1
        hold_cycles(4);
        set_mem_ack(1'b1);
        wait_until_drained();
        check_value("issued source", issue_src[base], 2);
        check_value("issued source", issue_src[base+1], 0);
        check_value("issued source", issue_src[base+2], 1);
    endtask

    task automatic critical_first();
        int base;
        set_mem_ack(1'b1);
        send_requests(3'b100, 3'b000);  // rotation now starts at source 0
        wait_until_drained();
        base = issue_src.size();
        set_mem_ack(1'b0);
        send_requests(3'b111, 3'b100);
        hold_cycles(4);
        set_mem_ack(1'b1);
        wait_until_drained();
        check_value("issued source", issue_src[base], 2);
        check_value("issued source", issue_src[base+1], 0);
        check_value("issued source", issue_src[base+2], 1);
    endtask

    task automatic full_queue_backpressure();
        int base;
        base = issue_src.size();
        set_mem_ack(1'b0);
        send_requests(3'b001, 3'b000);  // parks in the arbiter output
        hold_cycles(3);
        check_value("mem_req_valid", mem_req_valid, 1);
        send_requests(3'b110, 3'b000);
        send_requests(3'b100, 3'b000);
        @(negedge clk_in);
        check_value("req_ack", req_ack, 3'b011);
        hold_cycles(4);
        set_mem_ack(1'b1);
        wait_until_drained();
        // full queue 2 goes ahead of source 1, which rotation alone would favor
        check_value("issued source", issue_src[base], 0);
        check_value("issued source", issue_src[base+1], 2);
        check_value("issued source", issue_src[base+2], 1);
        check_value("issued source", issue_src[base+3], 2);
    endtask

    task automatic outstanding_limit();
        int base;
        base = issue_src.size();
        set_mem_ack(1'b1);
        hold_resp = 1'b1;
        send_requests(3'b111, 3'b000);
        send_requests(3'b111, 3'b000);
        while (issue_src.size() - base < mem_cfg_pkg::MAX_OUTSTANDING)
            @(negedge clk_in);
        repeat (8)
        begin
            @(negedge clk_in);
            check_value("mem_req_valid", mem_req_valid, 0);
            check_value("issued count", issue_src.size() - base, mem_cfg_pkg::MAX_OUTSTANDING);
        end
        @(posedge clk_in);
        #1;
        hold_resp = 1'b0;
        wait_until_drained();
    endtask

    initial
    begin
        void'($urandom(10643));
        reset_in     = 1'b1;
        req_data     = '0;
        req_critical = '0;
        req_valid    = '0;
        mem_req_ack  = 1'b0;
        repeat (8) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        @(negedge clk_in);
        check_value("req_ack", req_ack, 3'b111);
        check_value("mem_req_valid", mem_req_valid, 0);
        check_value("resp_valid", resp_valid, 0);

        single_request();
        round_robin_order();
        critical_first();
        full_queue_backpressure();
        outstanding_limit();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter_top
(
    input  logic                                                    clk_in,
    input  logic                                                    reset_in,

    // requester side
    input  mem_req_pkg::mem_req_t [mem_cfg_pkg::NUM_SOURCES-1:0]    req_data,
    input  logic [mem_cfg_pkg::NUM_SOURCES-1:0]                     req_critical,
    input  logic [mem_cfg_pkg::NUM_SOURCES-1:0]                     req_valid,
    output logic [mem_cfg_pkg::NUM_SOURCES-1:0]                     req_ack,

    // memory side
    output mem_req_pkg::mem_req_t                                   mem_req,
    output logic                                                    mem_req_valid,
    input  logic                                                    mem_req_ack,
    input  mem_req_pkg::mem_resp_t                                  mem_resp,
    input  logic                                                    mem_resp_valid,

    // return side
    output mem_req_pkg::mem_resp_t                                  resp_data,
    output logic [mem_cfg_pkg::NUM_SOURCES-1:0]                     resp_valid
);

    req_stream_if q2arb [mem_cfg_pkg::NUM_SOURCES] ();
    req_stream_if arb2rt ();

    for (genvar i = 0; i < mem_cfg_pkg::NUM_SOURCES; i++)
    begin : g_queue
        assign q2arb[i].src = mem_req_pkg::src_id_t'(i);  // fixed queue index

        request_queue
        #(
            .DEPTH          (mem_cfg_pkg::QUEUE_DEPTH)
        )
        u_queue
        (
            .clk_in         (clk_in),
            .reset_in       (reset_in),
            .in_req         (req_data[i]),
            .in_critical    (req_critical[i]),
            .in_valid       (req_valid[i]),
            .in_ack         (req_ack[i]),
            .out            (q2arb[i])
        );
    end

    priority_arbiter u_arbiter
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .in             (q2arb),
        .out            (arb2rt)
    );

    response_router u_router
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .in             (arb2rt),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ack    (mem_req_ack),
        .mem_resp       (mem_resp),
        .mem_resp_valid (mem_resp_valid),
        .resp_data      (resp_data),
        .resp_valid     (resp_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/response_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module response_router
(
    input  logic                                clk_in,
    input  logic                                reset_in,

    req_stream_if.sink                          in,

    output mem_req_pkg::mem_req_t               mem_req,
    output logic                                mem_req_valid,
    input  logic                                mem_req_ack,

    input  mem_req_pkg::mem_resp_t              mem_resp,
    input  logic                                mem_resp_valid,

    output mem_req_pkg::mem_resp_t              resp_data,
    output logic [mem_cfg_pkg::NUM_SOURCES-1:0] resp_valid
);

    // source ids of issued requests, oldest at rd_ptr
    mem_req_pkg::src_id_t               tag_mem [mem_cfg_pkg::MAX_OUTSTANDING];
    logic [mem_cfg_pkg::TAG_PTR_W:0]    wr_ptr;
    logic [mem_cfg_pkg::TAG_PTR_W:0]    rd_ptr;
    mem_req_pkg::src_id_t               head_src;
    logic                               tag_full;
    logic                               tag_empty;
    logic                               push;
    logic                               pop;

    assign tag_empty = (wr_ptr == rd_ptr);
    assign tag_full  = (wr_ptr[mem_cfg_pkg::TAG_PTR_W] != rd_ptr[mem_cfg_pkg::TAG_PTR_W]) &&
                       (wr_ptr[mem_cfg_pkg::TAG_PTR_W-1:0] == rd_ptr[mem_cfg_pkg::TAG_PTR_W-1:0]);

    // throttle issue at the outstanding limit
    assign mem_req       = in.req;
    assign mem_req_valid = in.valid && !tag_full;
    assign in.ack        = mem_req_ack && !tag_full;

    assign push     = mem_req_valid && mem_req_ack;
    assign pop      = mem_resp_valid && !tag_empty;
    assign head_src = tag_mem[rd_ptr[mem_cfg_pkg::TAG_PTR_W-1:0]];

    always_ff @(posedge clk_in)
    begin
        if (push)
            tag_mem[wr_ptr[mem_cfg_pkg::TAG_PTR_W-1:0]] <= in.src;
        if (mem_resp_valid)
            resp_data <= mem_resp;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            resp_valid <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            for (int i = 0; i < mem_cfg_pkg::NUM_SOURCES; i++)
                resp_valid[i] <= pop && (head_src == i);  // one-hot pulse
        end
    end

endmodule

`default_nettype wire

// ==== hdl/priority_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module priority_arbiter
(
    input  logic            clk_in,
    input  logic            reset_in,

    req_stream_if.sink      in [mem_cfg_pkg::NUM_SOURCES],
    req_stream_if.source    out
);

    mem_req_pkg::mem_req_t                  in_req [mem_cfg_pkg::NUM_SOURCES];
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    in_valid;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    in_critical;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    just_acked;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    cand_valid;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    cand_crit;

    // doubled vectors make the rotation a plain shift
    logic [2*mem_cfg_pkg::NUM_SOURCES-1:0]  valid_dbl;
    logic [2*mem_cfg_pkg::NUM_SOURCES-1:0]  crit_dbl;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    valid_rot;
    logic [mem_cfg_pkg::NUM_SOURCES-1:0]    crit_rot;
    int                                     shift_amt;

    logic                                   crit_found;
    logic                                   valid_found;
    mem_req_pkg::src_id_t                   crit_sel;
    mem_req_pkg::src_id_t                   valid_sel;
    mem_req_pkg::src_id_t                   pick;
    logic                                   pick_valid;

    mem_req_pkg::src_id_t                   last_sel;
    mem_req_pkg::mem_req_t                  out_req_q;
    logic                                   out_crit_q;
    logic                                   out_valid_q;
    logic                                   done;
    logic                                   load;

    // position k of the rotated vector back to a source index
    function automatic mem_req_pkg::src_id_t rot_index(mem_req_pkg::src_id_t base, int k);
        int idx;
        idx = int'(base) + 1 + k;
        if (idx >= mem_cfg_pkg::NUM_SOURCES)
            idx = idx - mem_cfg_pkg::NUM_SOURCES;
        return mem_req_pkg::src_id_t'(idx);
    endfunction

    assign done = out_valid_q && out.ack;
    assign load = !out_valid_q || done;

    for (genvar i = 0; i < mem_cfg_pkg::NUM_SOURCES; i++)
    begin : g_src
        assign in_req[i]      = in[i].req;
        assign in_valid[i]    = in[i].valid;
        assign in_critical[i] = in[i].critical;
        assign just_acked[i]  = done && (last_sel == i);  // old head still visible
        assign in[i].ack      = done && (last_sel == i);
    end

    assign cand_valid = in_valid & ~just_acked;
    assign cand_crit  = cand_valid & in_critical;

    assign shift_amt = int'(last_sel) + 1;
    assign valid_dbl = {cand_valid, cand_valid} >> shift_amt;
    assign crit_dbl  = {cand_crit, cand_crit} >> shift_amt;
    assign valid_rot = valid_dbl[mem_cfg_pkg::NUM_SOURCES-1:0];
    assign crit_rot  = crit_dbl[mem_cfg_pkg::NUM_SOURCES-1:0];

    always_comb
    begin
        crit_found  = 1'b0;
        valid_found = 1'b0;
        crit_sel    = '0;
        valid_sel   = '0;
        for (int k = 0; k < mem_cfg_pkg::NUM_SOURCES; k++)
        begin
            if (!crit_found && crit_rot[k])
            begin
                crit_found = 1'b1;
                crit_sel   = rot_index(last_sel, k);
            end
            if (!valid_found && valid_rot[k])
            begin
                valid_found = 1'b1;
                valid_sel   = rot_index(last_sel, k);
            end
        end
    end

    assign pick       = crit_found ? crit_sel : valid_sel;  // critical class wins
    assign pick_valid = crit_found || valid_found;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            out_valid_q <= 1'b0;
            last_sel    <= mem_req_pkg::src_id_t'(mem_cfg_pkg::NUM_SOURCES - 1);
        end
        else if (load)
        begin
            out_valid_q <= pick_valid;
            if (pick_valid)
                last_sel <= pick;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load && pick_valid)
        begin
            out_req_q  <= in_req[pick];
            out_crit_q <= in_critical[pick];
        end
    end

    assign out.valid    = out_valid_q;
    assign out.req      = out_req_q;
    assign out.critical = out_crit_q;
    assign out.src      = last_sel;  // registered along with the payload

endmodule

`default_nettype wire

// ==== hdl/request_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module request_queue
#(
    parameter int DEPTH = mem_cfg_pkg::QUEUE_DEPTH
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    input  mem_req_pkg::mem_req_t   in_req,
    input  logic                    in_critical,
    input  logic                    in_valid,
    output logic                    in_ack,

    req_stream_if.source            out
);

    localparam int PTR_W = $clog2(DEPTH);

    mem_req_pkg::mem_req_t  req_mem [DEPTH];
    logic                   crit_mem [DEPTH];

    // extra msb tells full from empty
    logic [PTR_W:0]         wr_ptr;
    logic [PTR_W:0]         rd_ptr;

    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign in_ack = !full;
    assign push   = in_valid && in_ack;
    assign pop    = out.valid && out.ack;

    assign out.valid    = !empty;
    assign out.req      = req_mem[rd_ptr[PTR_W-1:0]];
    // a full queue is escalated so the arbiter drains it first
    assign out.critical = crit_mem[rd_ptr[PTR_W-1:0]] || full;

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            req_mem[wr_ptr[PTR_W-1:0]]  <= in_req;
            crit_mem[wr_ptr[PTR_W-1:0]] <= in_critical;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/req_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// request channel with a valid/ack handshake
// payload stays stable while valid is high and ack is low
interface req_stream_if;

    mem_req_pkg::mem_req_t  req;
    logic                   critical;
    mem_req_pkg::src_id_t   src;
    logic                   valid;
    logic                   ack;     // may depend combinationally on valid

    modport source
    (
        output req,
        output critical,
        output src,
        output valid,
        input  ack
    );

    modport sink
    (
        input  req,
        input  critical,
        input  src,
        input  valid,
        output ack
    );

endinterface

`default_nettype wire

// ==== hdl/mem_req_pkg.sv ====
`default_nettype none

package mem_req_pkg;

    // two bits so that a request packs into 66 bits
    typedef enum logic [1:0]
    {
        op_read  = 2'd0,
        op_write = 2'd1
    } mem_op_e;

    typedef logic [mem_cfg_pkg::SRC_W-1:0] src_id_t;

    typedef struct packed
    {
        mem_op_e                          op;
        logic [mem_cfg_pkg::ADDR_W-1:0]   addr;
        logic [mem_cfg_pkg::DATA_W-1:0]   wdata;  // ignored for reads
    } mem_req_t;

    typedef struct packed
    {
        logic [mem_cfg_pkg::DATA_W-1:0]   rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== hdl/mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

    // requesters: 0 instruction fetch, 1 data cache, 2 DMA engine
    localparam int NUM_SOURCES = 3;

    // entries per request queue, power of two
    localparam int QUEUE_DEPTH = 2;

    // issued requests still waiting for their response
    localparam int MAX_OUTSTANDING = 4;

    localparam int TAG_PTR_W = $clog2(MAX_OUTSTANDING);

    // width of a source id
    localparam int SRC_W = 2;

    localparam int ADDR_W = 32; // memory address
    localparam int DATA_W = 32; // read and write data

endpackage

`default_nettype wire
